// ==== logic/fetch_consts.svh ====
// Opcode, NOP word and memory size macros, included by the fetch RTL and the bench
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_JR     5'b00101
`define OP_JAL    5'b00110
`define OP_ADDI   5'b01000
`define OP_BEQZ   5'b01100
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_ALU    5'b11011

`define NOP_WORD  16'h0800

// immSel encodings
`define IMM_NONE  2'd0
`define IMM_5     2'd1
`define IMM_8     2'd2
`define IMM_11    2'd3

`define IMEM_WORDS     128
`define IMEM_ADDR_BITS 7
`endif

// ==== logic/fetchPkg.sv ====
// Instruction word views and control bundle type, shared by the fetch RTL and its bench
package fetchPkg;

    // Register format, ALU and compare operations
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] funct;
    } rFormat;

    // Immediate format, loads, stores and ADDI
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFormat;

    typedef union packed {
        rFormat rForm;
        iFormat iForm;
    } instrWord;

    typedef struct packed {
        logic       regWrite;
        logic [2:0] writeRegAddr;
        logic       memEnable;
        logic       memWr;
        logic       val2Reg;       // Load result goes to register
        logic       aluSel;        // Immediate as ALU operand B
        logic [1:0] immSel;        // See IMM_* encodings
        logic       linkReg;
        logic       branchFlag;
        logic       jumpFlag;
        logic       regJmp;
        logic       halt;
        logic       ctrlErr;
        logic       valid;
    } ctrlBundle;

endpackage

// ==== logic/programCounter.sv ====
// Program counter register with halt, stall, redirect and register-jump selection
module programCounter (
    input  logic        clk,
    input  logic        reset,
    input  logic        halt,
    input  logic        stall,
    input  logic        pcSel,
    input  logic        regJmp,
    input  logic [15:0] branchTarget,
    input  logic [15:0] regData,
    input  logic [7:0]  jumpImm,
    output logic [15:0] pc
);

    logic [15:0] jumpOffset;
    logic [15:0] jumpAddr;
    logic [15:0] seqAddr;
    logic [15:0] nextPc;

    // JR target is rs plus sign-extended 8-bit immediate
    assign jumpOffset = {{8{jumpImm[7]}}, jumpImm};
    assign jumpAddr   = regData + jumpOffset;

    // Sequential fetch stays inside the 256-byte window
    assign seqAddr = {8'h00, pc[7:0] + 8'd2};

    always_comb begin
        if (halt) begin
            nextPc = pc;                                  // Parked until reset
        end else if (stall) begin
            nextPc = pc;                                  // Load-use bubble
        end else if (pcSel) begin
            nextPc = {branchTarget[15:1], 1'b0};
        end else if (regJmp) begin
            nextPc = {jumpAddr[15:1], 1'b0};
        end else begin
            nextPc = seqAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= 16'h0000;
        end else begin
            pc <= nextPc;
        end
    end

    // Word alignment must survive every load path
    pcAligned: assert property (@(posedge clk) disable iff (reset) pc[0] == 1'b0)
        else $error("pc not halfword aligned: %h", pc);

endmodule

// ==== logic/instrMemory.sv ====
// Word-addressed instruction store, written by the bench and read combinationally by fetch
`include "fetch_consts.svh"

module instrMemory (
    input  logic                           clk,
    input  logic                           writeEn,
    input  logic [`IMEM_ADDR_BITS-1:0]     writeAddr,
    input  logic [`IMEM_ADDR_BITS-1:0]     readAddr,
    input  logic [15:0]                    writeData,
    output fetchPkg::instrWord             readData
);

    import fetchPkg::*;

    instrWord memArray [`IMEM_WORDS];

    // Loaded while the core is held in reset
    always_ff @(posedge clk) begin
        if (writeEn) begin
            memArray[writeAddr] <= writeData;
        end
    end

    // Fetch sees the word in the same cycle
    assign readData = memArray[readAddr];

endmodule

// ==== logic/controlDecoder.sv ====
// Opcode decoder producing the control bundle and destination register for one instruction
`include "fetch_consts.svh"

module controlDecoder (
    input  fetchPkg::instrWord  instr,
    output fetchPkg::ctrlBundle ctrl
);

    import fetchPkg::*;

    // Destination register source
    localparam logic [1:0] destRs   = 2'd0;
    localparam logic [1:0] destRdR  = 2'd1;
    localparam logic [1:0] destLink = 2'd2;
    localparam logic [1:0] destRdI  = 2'd3;

    logic [1:0] destSel;
    logic [2:0] selAddr;

    always_comb begin
        ctrl    = '0;
        destSel = destRs;
        ctrl.valid = 1'b1;

        case (instr.rForm.opcode)
            `OP_HALT: ctrl.halt = 1'b1;
            `OP_NOP: ;                                    // Valid, nothing else
            `OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSel   = 1'b1;
                ctrl.immSel   = `IMM_5;
                destSel       = destRdI;
            end
            `OP_ST: begin
                ctrl.memEnable = 1'b1;
                ctrl.memWr     = 1'b1;
                ctrl.aluSel    = 1'b1;                    // Address is rs + imm
                ctrl.immSel    = `IMM_5;
            end
            `OP_LD: begin
                ctrl.memEnable = 1'b1;
                ctrl.regWrite  = 1'b1;
                ctrl.val2Reg   = 1'b1;
                ctrl.aluSel    = 1'b1;
                ctrl.immSel    = `IMM_5;
                destSel        = destRdI;
            end
            `OP_ALU: begin
                ctrl.regWrite = 1'b1;
                destSel       = destRdR;
            end
            `OP_BEQZ: begin
                ctrl.branchFlag = 1'b1;                   // Resolved downstream
                ctrl.immSel     = `IMM_8;
            end
            `OP_J: begin
                ctrl.jumpFlag = 1'b1;
                ctrl.immSel   = `IMM_11;
            end
            `OP_JR: begin
                ctrl.regJmp = 1'b1;
                ctrl.immSel = `IMM_8;
            end
            `OP_JAL: begin
                ctrl.jumpFlag = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.linkReg  = 1'b1;
                ctrl.immSel   = `IMM_11;
                destSel       = destLink;
            end
            default: begin
                ctrl.ctrlErr = 1'b1;                      // Illegal opcode
                ctrl.valid   = 1'b0;
            end
        endcase

        case (destSel)
            destRdR:  selAddr = instr.rForm.rd;
            destLink: selAddr = 3'd7;                     // Return address in R7
            destRdI:  selAddr = instr.iForm.rd;
            default:  selAddr = instr.rForm.rs;
        endcase

        // Only writers carry a destination
        ctrl.writeRegAddr = ctrl.regWrite ? selAddr : 3'b000;

        assert (!ctrl.memWr || ctrl.memEnable)
            else $error("store without memory enable, opcode %b", instr.rForm.opcode);
    end

endmodule

// ==== logic/hazardDetect.sv ====
// Load-use hazard detector that stalls fetch for one cycle behind a dependent load
`include "fetch_consts.svh"

module hazardDetect (
    input  logic                clk,
    input  logic                reset,
    input  fetchPkg::instrWord  instr,
    input  fetchPkg::ctrlBundle ctrl,
    output logic                stall
);

    import fetchPkg::*;

    logic       lastLoad;   // Issued instruction was LD
    logic [2:0] lastDest;
    logic [4:0] opcode;
    logic       rsUsed;
    logic       rtUsed;
    logic       rsHit;
    logic       rtHit;

    assign opcode = instr.rForm.opcode;

    // Source fields in use for this opcode
    assign rsUsed = !(opcode inside {`OP_HALT, `OP_NOP, `OP_J, `OP_JAL});
    assign rtUsed = (opcode == `OP_ALU) || (opcode == `OP_ST);

    assign rsHit = rsUsed && (lastDest == instr.rForm.rs);
    assign rtHit = rtUsed && (lastDest == instr.rForm.rt);

    assign stall = lastLoad && (rsHit || rtHit);

    // The NOP issued on a stall clears the load state
    always_ff @(posedge clk) begin
        if (reset) begin
            lastLoad <= 1'b0;
        end else begin
            lastLoad <= ctrl.val2Reg && !stall;
        end
    end

    always_ff @(posedge clk) begin
        lastDest <= ctrl.writeRegAddr;
    end

    // Bubble is a single cycle
    singleStall: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
        else $error("load-use stall held for two cycles");

endmodule

// ==== logic/fetchStage.sv ====
// Fetch stage top level joining PC, instruction memory, decode and load-use stall
`include "fetch_consts.svh"

module fetchStage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pcSel,
    input  logic [15:0]                branchTarget,
    input  logic [15:0]                regData,
    input  logic                       imemWrite,
    input  logic [`IMEM_ADDR_BITS-1:0] imemAddr,
    input  logic [15:0]                imemData,
    output logic [15:0]                pc,
    output fetchPkg::instrWord         instr,
    output fetchPkg::ctrlBundle        ctrl
);

    import fetchPkg::*;

    instrWord  rawInstr;
    ctrlBundle rawCtrl;
    logic      stall;

    // Halt and JR act from the issued word, not the raw fetch
    programCounter pcReg (
        .clk         (clk),
        .reset       (reset),
        .halt        (ctrl.halt),
        .stall       (stall),
        .pcSel       (pcSel),
        .regJmp      (ctrl.regJmp),
        .branchTarget(branchTarget),
        .regData     (regData),
        .jumpImm     ({instr.iForm.rd, instr.iForm.imm}),
        .pc          (pc)
    );

    instrMemory imem (
        .clk      (clk),
        .writeEn  (imemWrite),
        .writeAddr(imemAddr),
        .readAddr (pc[`IMEM_ADDR_BITS:1]),     // Word index
        .writeData(imemData),
        .readData (rawInstr)
    );

    controlDecoder rawDecode (
        .instr(rawInstr),
        .ctrl (rawCtrl)
    );

    hazardDetect hazard (
        .clk  (clk),
        .reset(reset),
        .instr(rawInstr),
        .ctrl (rawCtrl),
        .stall(stall)
    );

    // Bubble in place of the dependent reader
    assign instr = stall ? `NOP_WORD : rawInstr;

    controlDecoder issueDecode (
        .instr(instr),
        .ctrl (ctrl)
    );

endmodule

// ==== bench/fetchChecker.sv ====
// Bench monitor that models the fetch stage and compares pc, instr and ctrl each cycle
`include "fetch_consts.svh"

module fetchChecker (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       pcSel,
    input  logic [15:0]                branchTarget,
    input  logic [15:0]                regData,
    input  logic                       imemWrite,
    input  logic [`IMEM_ADDR_BITS-1:0] imemAddr,
    input  logic [15:0]                imemData,
    input  logic [15:0]                pc,
    input  fetchPkg::instrWord         instr,
    input  fetchPkg::ctrlBundle        ctrl,
    output logic                       haltedLong,
    output int                         errorCount = 0,
    output int                         checkCount = 0,
    output int                         stallCount = 0
);

    import fetchPkg::*;

    instrWord    mirror [`IMEM_WORDS];                    // Copy of the program
    logic [15:0] modelPc  = 16'h0000;
    logic        lastLoad = 1'b0;
    logic [2:0]  lastDest = 3'b000;
    int          haltCount = 0;
    instrWord    rawWord;
    instrWord    issuedWord;
    ctrlBundle   rawExp;
    ctrlBundle   issExp;
    logic        stallExp;
    logic [15:0] jumpTarget;

    assign haltedLong = (haltCount >= 8);

    function automatic ctrlBundle expectDecode(input instrWord w);
        ctrlBundle c;
        c       = '0;
        c.valid = 1'b1;
        case (w.rForm.opcode)
            `OP_HALT: c.halt = 1'b1;
            `OP_NOP:  c.valid = 1'b1;
            `OP_ADDI, `OP_LD: begin
                c.regWrite     = 1'b1;
                c.writeRegAddr = w.iForm.rd;
                c.aluSel       = 1'b1;
                c.immSel       = `IMM_5;
                c.memEnable    = (w.rForm.opcode == `OP_LD);
                c.val2Reg      = (w.rForm.opcode == `OP_LD);
            end
            `OP_ST: begin
                c.memEnable = 1'b1;
                c.memWr     = 1'b1;
                c.aluSel    = 1'b1;
                c.immSel    = `IMM_5;
            end
            `OP_ALU: begin
                c.regWrite     = 1'b1;
                c.writeRegAddr = w.rForm.rd;
            end
            `OP_BEQZ: begin
                c.branchFlag = 1'b1;
                c.immSel     = `IMM_8;
            end
            `OP_J: begin
                c.jumpFlag = 1'b1;
                c.immSel   = `IMM_11;
            end
            `OP_JR: begin
                c.regJmp = 1'b1;
                c.immSel = `IMM_8;
            end
            `OP_JAL: begin
                c.jumpFlag     = 1'b1;
                c.regWrite     = 1'b1;
                c.linkReg      = 1'b1;
                c.writeRegAddr = 3'd7;
                c.immSel       = `IMM_11;
            end
            default: begin
                c.ctrlErr = 1'b1;
                c.valid   = 1'b0;
            end
        endcase
        return c;
    endfunction

    // True when the word reads the register a load is about to write
    function automatic logic readsDest(input instrWord w, input logic [2:0] dest);
        logic [4:0] op;
        logic       rsRead;
        logic       rtRead;
        op     = w.rForm.opcode;
        rsRead = (op != `OP_HALT) && (op != `OP_NOP) && (op != `OP_J) && (op != `OP_JAL);
        rtRead = (op == `OP_ALU) || (op == `OP_ST);
        return (rsRead && (w.rForm.rs == dest)) || (rtRead && (w.rForm.rt == dest));
    endfunction

    task automatic compareField(input string name, input logic [15:0] expVal,
                                input logic [15:0] gotVal);
        if (gotVal !== expVal) begin
            errorCount++;
            $display("MISMATCH time %0t %s expected %h got %h", $time, name, expVal, gotVal);
        end
    endtask

    always @(posedge clk) begin
        rawWord    = mirror[modelPc[7:1]];
        rawExp     = expectDecode(rawWord);
        stallExp   = lastLoad && readsDest(rawWord, lastDest);
        issuedWord = stallExp ? instrWord'(`NOP_WORD) : rawWord;
        issExp     = expectDecode(issuedWord);

        if (reset) begin
            modelPc   = 16'h0000;
            lastLoad  = 1'b0;
            haltCount = 0;
        end else begin
            checkCount++;
            if (stallExp) begin
                stallCount++;
            end
            compareField("pc", modelPc, pc);
            compareField("instr", issuedWord, instr);
            compareField("ctrl.regWrite", 16'(issExp.regWrite), 16'(ctrl.regWrite));
            compareField("ctrl.writeRegAddr", 16'(issExp.writeRegAddr), 16'(ctrl.writeRegAddr));
            compareField("ctrl.memEnable", 16'(issExp.memEnable), 16'(ctrl.memEnable));
            compareField("ctrl.memWr", 16'(issExp.memWr), 16'(ctrl.memWr));
            compareField("ctrl.val2Reg", 16'(issExp.val2Reg), 16'(ctrl.val2Reg));
            compareField("ctrl.aluSel", 16'(issExp.aluSel), 16'(ctrl.aluSel));
            compareField("ctrl.immSel", 16'(issExp.immSel), 16'(ctrl.immSel));
            compareField("ctrl.linkReg", 16'(issExp.linkReg), 16'(ctrl.linkReg));
            compareField("ctrl.branchFlag", 16'(issExp.branchFlag), 16'(ctrl.branchFlag));
            compareField("ctrl.jumpFlag", 16'(issExp.jumpFlag), 16'(ctrl.jumpFlag));
            compareField("ctrl.regJmp", 16'(issExp.regJmp), 16'(ctrl.regJmp));
            compareField("ctrl.halt", 16'(issExp.halt), 16'(ctrl.halt));
            compareField("ctrl.ctrlErr", 16'(issExp.ctrlErr), 16'(ctrl.ctrlErr));
            compareField("ctrl.valid", 16'(issExp.valid), 16'(ctrl.valid));

            // Next PC in priority order
            jumpTarget = regData + 16'($signed(issuedWord[7:0]));
            if (issExp.halt || stallExp) begin
                modelPc = modelPc;
            end else if (pcSel) begin
                modelPc = {branchTarget[15:1], 1'b0};
            end else if (issExp.regJmp) begin
                modelPc = {jumpTarget[15:1], 1'b0};
            end else begin
                modelPc = (modelPc + 16'd2) & 16'h00FF;
            end
            lastLoad  = rawExp.val2Reg && !stallExp;      // Bubble clears the load
            haltCount = ctrl.halt ? haltCount + 1 : 0;
        end
        lastDest = rawExp.writeRegAddr;

        if (imemWrite) begin
            mirror[imemAddr] = imemData;
        end
    end

endmodule

// ==== bench/fetchStageBench.sv ====
// Testbench top for the fetch stage: clock, reset, random program load, random redirects
`include "fetch_consts.svh"

module fetchStageBench;

    import fetchPkg::*;

    localparam int LOAD_CYCLES    = `IMEM_WORDS;
    localparam int RUN_CYCLES     = 400;
    localparam int TIMEOUT_CYCLES = 2 + LOAD_CYCLES + RUN_CYCLES + 70;

    logic                       clk;
    logic                       reset;
    logic                       pcSel;
    logic [15:0]                branchTarget;
    logic [15:0]                regData;
    logic                       imemWrite;
    logic [`IMEM_ADDR_BITS-1:0] imemAddr;
    logic [15:0]                imemData;
    logic [15:0]                pc;
    instrWord                   instr;
    ctrlBundle                  ctrl;

    logic        haltedLong;
    int          errorCount;
    int          checkCount;
    int          stallCount;
    int          restartCount;
    int          cycleCount;
    logic [15:0] lfsrState;

    fetchStage i_dut (
        .clk         (clk),
        .reset       (reset),
        .pcSel       (pcSel),
        .branchTarget(branchTarget),
        .regData     (regData),
        .imemWrite   (imemWrite),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .pc          (pc),
        .instr       (instr),
        .ctrl        (ctrl)
    );

    fetchChecker fetchCheck (
        .clk         (clk),
        .reset       (reset),
        .pcSel       (pcSel),
        .branchTarget(branchTarget),
        .regData     (regData),
        .imemWrite   (imemWrite),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .pc          (pc),
        .instr       (instr),
        .ctrl        (ctrl),
        .haltedLong  (haltedLong),
        .errorCount  (errorCount),
        .checkCount  (checkCount),
        .stallCount  (stallCount)
    );

    always #50 clk = ~clk;

    // Galois form, taps 16,14,13,11
    function automatic logic [15:0] nextLfsr(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int k = 0; k < count; k++) begin
            lfsrState = nextLfsr(lfsrState);
            bits      = {bits[14:0], lfsrState[0]};
        end
    endtask

    function automatic logic [4:0] pickOpcode(input int index);
        case (index)
            0:       return `OP_HALT;
            1:       return `OP_NOP;
            2:       return `OP_J;
            3:       return `OP_JR;
            4:       return `OP_JAL;
            5:       return `OP_ADDI;
            6:       return `OP_BEQZ;
            7:       return `OP_ST;
            8:       return `OP_LD;
            9:       return `OP_ALU;
            default: return 5'b11111;                     // Illegal opcode
        endcase
    endfunction

    task automatic makeWord(output logic [15:0] word);
        logic [15:0] bits;
        logic [4:0]  op;
        takeBits(4, bits);
        op = pickOpcode(int'(bits[3:0]) % 11);
        if (op == `OP_HALT) begin
            takeBits(2, bits);
            if (bits[1:0] != 2'b11) begin
                op = `OP_ADDI;                            // Keeps HALT near 1 in 32
            end
        end
        takeBits(11, bits);
        word = {op, bits[10:0]};
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        logic [15:0] bits;
        logic [15:0] word;
        clk          = 1'b0;
        reset        = 1'b1;
        pcSel        = 1'b0;
        branchTarget = '0;
        regData      = '0;
        imemWrite    = 1'b0;
        imemAddr     = '0;
        imemData     = '0;
        lfsrState    = 16'd6;
        restartCount = 0;
        cycleCount   = 0;
        repeat (2) @(negedge clk);

        // Program load while the core sits in reset
        for (int i = 0; i < LOAD_CYCLES; i++) begin
            makeWord(word);
            imemWrite = 1'b1;
            imemAddr  = `IMEM_ADDR_BITS'(i);
            imemData  = word;
            @(negedge clk);
        end
        imemWrite = 1'b0;
        reset     = 1'b0;

        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            takeBits(3, bits);
            pcSel = (bits[2:0] == 3'b000);                // About 1 in 8
            takeBits(16, bits);
            branchTarget = bits;
            takeBits(16, bits);
            regData = bits;
            if (haltedLong) begin
                reset = 1'b1;                             // Restart a parked core
                restartCount++;
            end else begin
                reset = 1'b0;
            end
            @(negedge clk);
        end

        $display("Checks %0d, stalls %0d, halt restarts %0d, mismatches %0d",
                 checkCount, stallCount, restartCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== fetchStage.f ====
+incdir+logic
logic/fetchPkg.sv
logic/programCounter.sv
logic/instrMemory.sv
logic/controlDecoder.sv
logic/hazardDetect.sv
logic/fetchStage.sv
bench/fetchChecker.sv
bench/fetchStageBench.sv

// ==== run.sh ====
#!/bin/sh
# Builds the fetch stage testbench with Verilator, runs it and checks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 -f fetchStage.f --top-module fetchStageBench
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VfetchStageBench)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q '^Regression passed$'; then
    exit 0
fi
exit 1
